/* decode_top.f */
hdl/rv_decode_pkg.sv
hdl/decode_ctrl.sv
hdl/inst_decoder.sv
hdl/imm_gen.sv
hdl/operand_sel.sv
hdl/reg_file.sv
hdl/decode_top.sv
dv/decode_tb.sv

/* Bender.yml */
package:
  name: decode_top

sources:
  - files:
      - hdl/rv_decode_pkg.sv
      - hdl/decode_ctrl.sv
      - hdl/inst_decoder.sv
      - hdl/imm_gen.sv
      - hdl/operand_sel.sv
      - hdl/reg_file.sv
      - hdl/decode_top.sv
  - target: test
    files:
      - dv/decode_tb.sv

/* dv/decode_tb.sv */
// testbench for the rv64i decode stage.
// random traffic with a reference model, checked by concurrent assertions.
module decode_tb import rv_decode_pkg::*; ();

  localparam int XLEN     = 64;
  localparam int WAIT_MAX = 50;

  logic            i_clk;
  logic            i_rst;
  logic            i_fetched_req;
  logic            i_decoded_ack;
  logic [31:0]     i_inst;
  logic [XLEN-1:0] i_pc;
  logic [XLEN-1:0] i_pc_old;
  logic [XLEN-1:0] i_pc_pred;
  logic            i_wb_en;
  reg_idx_t        i_wb_rd;
  logic [XLEN-1:0] i_wb_data;
  logic [XLEN-1:0] i_csr_rdata;
  logic            o_fetched_ack, o_decoded_req;
  logic            o_rs1_ren, o_rs2_ren, o_memren, o_memwen, o_skip_difftest;
  reg_idx_t        o_rs1, o_rs2, o_rd;
  itype_e          o_itype;
  logic [6:0]      o_opcode, o_funct7;
  logic [2:0]      o_funct3;
  logic [11:0]     o_csr_addr;
  csr_op_e         o_csr_op;
  logic [XLEN-1:0] o_memaddr, o_memwdata, o_op1, o_op2, o_t1, o_csr_wdata, o_pc_pred;

  // reference model state.
  logic [XLEN-1:0] shadow [32];
  logic            m_req;
  logic            m_ack;
  logic [31:0]     h_inst;
  logic [XLEN-1:0] h_pc, h_pred;
  logic [2:0]      m_itype;
  logic [1:0]      m_ren; // {rs1, rs2}.
  logic [1:0]      m_csr_op;
  reg_idx_t        m_rs1, m_rs2, m_rd;
  logic            m_memren, m_memwen, m_skip;
  logic [11:0]     m_csr_addr;
  logic [XLEN-1:0] m_memaddr, m_memwdata, m_op1, m_op2, m_t1, m_csr_wdata;

  int   errors = 0;
  int   tests = 0;
  int   items = 0;
  int   mark = 0;
  bit   timed_out = 0;
  event stop_ev;

  decode_top #(.XLEN(XLEN)) UUT (.*);

  always #10 i_clk = ~i_clk;

  // single slot stage, ready when empty or when the held item is taken.
  assign m_ack = !m_req || i_decoded_ack;

  // the model tracks the handshake and keeps its own copy of the held item.
  always @(posedge i_clk) begin
    if (i_rst) begin
      m_req <= 1'b0;
    end else if (i_fetched_req && m_ack) begin
      m_req  <= 1'b1;
      h_inst <= i_inst;
      h_pc   <= i_pc;
      h_pred <= i_pc_pred;
    end else if (i_decoded_ack) begin
      m_req <= 1'b0;
    end
    if (!i_rst && o_decoded_req && i_decoded_ack) items++;
  end

  always_comb begin
    logic [XLEN-1:0] v1;
    logic [XLEN-1:0] v2;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;
    v1    = shadow[h_inst[19:15]];
    v2    = shadow[h_inst[24:20]];
    imm_i = $signed(h_inst[31:20]);
    imm_s = $signed({h_inst[31:25], h_inst[11:7]});
    imm_b = $signed({h_inst[31], h_inst[7], h_inst[30:25], h_inst[11:8], 1'b0});
    imm_u = $signed({h_inst[31:12], 12'h000});
    imm_j = $signed({h_inst[31], h_inst[19:12], h_inst[20], h_inst[30:21], 1'b0});
    {m_itype, m_ren, m_rd} = {itype_none, 2'b00, h_inst[11:7]};
    {m_memren, m_memwen, m_skip} = 3'b000;
    {m_memaddr, m_memwdata, m_t1} = '0;
    {m_op1, m_op2} = '0;
    {m_csr_addr, m_csr_op, m_csr_wdata} = '0;
    case (h_inst[6:0])
      op_reg: begin
        {m_itype, m_ren} = {itype_r, 2'b11};
        {m_op1, m_op2} = {v1, v2};
      end
      op_imm, op_load: begin
        {m_itype, m_ren} = {itype_i, 2'b10};
        {m_op1, m_op2} = {v1, imm_i};
        m_memren  = (h_inst[6:0] == op_load);
        m_memaddr = m_memren ? v1 + imm_i : '0;
      end
      op_store: begin
        {m_itype, m_ren, m_rd} = {itype_s, 2'b11, 5'd0};
        {m_op1, m_op2, m_memwdata} = {v1, imm_s, v2};
        {m_memwen, m_memaddr} = {1'b1, v1 + imm_s};
      end
      op_branch: begin
        {m_itype, m_ren, m_rd} = {itype_b, 2'b11, 5'd0};
        {m_op1, m_op2, m_t1} = {v1, v2, h_pc + imm_b};
      end
      op_jal: begin
        m_itype = itype_j;
        {m_op1, m_op2, m_t1} = {h_pc, 64'd4, h_pc + imm_j};
      end
      op_jalr: begin
        {m_itype, m_ren} = {itype_i, 2'b10};
        {m_op1, m_op2, m_t1} = {h_pc, 64'd4, (v1 + imm_i) & ~64'd1};
      end
      op_lui:   {m_itype, m_op1} = {itype_u, imm_u};
      op_auipc: {m_itype, m_op1, m_op2} = {itype_u, h_pc, imm_u};
      op_system: begin
        if (h_inst[14:12] != 3'b000) begin // funct3 zero is ecall or ebreak.
          {m_itype, m_ren} = {itype_csr, !h_inst[14], 1'b0};
          {m_csr_addr, m_csr_op} = {h_inst[31:20], h_inst[13:12]};
          m_csr_wdata = h_inst[14] ? 64'(h_inst[19:15]) : v1;
          m_op1       = i_csr_rdata;
          m_skip      = (h_inst[31:20] == csr_mcycle_addr);
        end
      end
      default: ;
    endcase
    m_rs1 = m_ren[1] ? h_inst[19:15] : 5'd0;
    m_rs2 = m_ren[0] ? h_inst[24:20] : 5'd0;
  end

  property held(got, want);
    @(posedge i_clk) disable iff (i_rst) o_decoded_req |-> got == want;
  endproperty

  assert property (held(o_itype, m_itype))
    else mismatch("o_itype", $sampled(m_itype), $sampled(o_itype));
  assert property (held(o_opcode, h_inst[6:0]))
    else mismatch("o_opcode", $sampled(h_inst[6:0]), $sampled(o_opcode));
  assert property (held(o_funct3, h_inst[14:12]))
    else mismatch("o_funct3", $sampled(h_inst[14:12]), $sampled(o_funct3));
  assert property (held(o_funct7, h_inst[31:25]))
    else mismatch("o_funct7", $sampled(h_inst[31:25]), $sampled(o_funct7));
  assert property (held(o_rs1_ren, m_ren[1]))
    else mismatch("o_rs1_ren", $sampled(m_ren[1]), $sampled(o_rs1_ren));
  assert property (held(o_rs2_ren, m_ren[0]))
    else mismatch("o_rs2_ren", $sampled(m_ren[0]), $sampled(o_rs2_ren));
  assert property (held(o_rs1, m_rs1)) else mismatch("o_rs1", $sampled(m_rs1), $sampled(o_rs1));
  assert property (held(o_rs2, m_rs2)) else mismatch("o_rs2", $sampled(m_rs2), $sampled(o_rs2));
  assert property (held(o_rd, m_rd)) else mismatch("o_rd", $sampled(m_rd), $sampled(o_rd));
  assert property (held(o_memren, m_memren))
    else mismatch("o_memren", $sampled(m_memren), $sampled(o_memren));
  assert property (held(o_memwen, m_memwen))
    else mismatch("o_memwen", $sampled(m_memwen), $sampled(o_memwen));
  assert property (held(o_memaddr, m_memaddr))
    else mismatch("o_memaddr", $sampled(m_memaddr), $sampled(o_memaddr));
  assert property (held(o_memwdata, m_memwdata))
    else mismatch("o_memwdata", $sampled(m_memwdata), $sampled(o_memwdata));
  assert property (held(o_op1, m_op1)) else mismatch("o_op1", $sampled(m_op1), $sampled(o_op1));
  assert property (held(o_op2, m_op2)) else mismatch("o_op2", $sampled(m_op2), $sampled(o_op2));
  assert property (held(o_t1, m_t1)) else mismatch("o_t1", $sampled(m_t1), $sampled(o_t1));
  assert property (held(o_csr_addr, m_csr_addr))
    else mismatch("o_csr_addr", $sampled(m_csr_addr), $sampled(o_csr_addr));
  assert property (held(o_csr_op, m_csr_op))
    else mismatch("o_csr_op", $sampled(m_csr_op), $sampled(o_csr_op));
  assert property (held(o_csr_wdata, m_csr_wdata))
    else mismatch("o_csr_wdata", $sampled(m_csr_wdata), $sampled(o_csr_wdata));
  assert property (held(o_pc_pred, h_pred))
    else mismatch("o_pc_pred", $sampled(h_pred), $sampled(o_pc_pred));
  assert property (held(o_skip_difftest, m_skip))
    else mismatch("o_skip_difftest", $sampled(m_skip), $sampled(o_skip_difftest));

  // handshake rules.
  assert property (@(posedge i_clk) $fell(i_rst) |-> !o_decoded_req && o_fetched_ack)
    else fault("stage was not empty and ready after reset");
  assert property (@(posedge i_clk) disable iff (i_rst) o_decoded_req == m_req)
    else mismatch("o_decoded_req", $sampled(m_req), $sampled(o_decoded_req));
  assert property (@(posedge i_clk) disable iff (i_rst) o_fetched_ack == m_ack)
    else mismatch("o_fetched_ack", $sampled(m_ack), $sampled(o_fetched_ack));

  task automatic mismatch(input string name, input logic [XLEN-1:0] want,
                          input logic [XLEN-1:0] got);
    $display("CHECK FAILED %s expected %h got %h", name, want, got);
    errors++;
  endtask

  task automatic fault(input string what);
    $display("error: %s", what);
    errors++;
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s", what);
    timed_out = 1'b1;
    -> stop_ev;
  endtask

  function automatic logic [31:0] rand_inst(input logic [6:0] op);
    return ($urandom() & 32'hffff_ff80) | 32'(op);
  endfunction

  function automatic logic [31:0] csr_inst(input logic [2:0] f3, input logic [11:0] addr);
    logic [31:0] r;
    r = $urandom();
    return {addr, r[19:15], f3, r[11:7], op_system};
  endfunction

  // offers one item and returns on the falling edge after it was taken.
  task automatic push_item(input logic [31:0] inst);
    int n;
    n             = 0;
    i_fetched_req = 1'b1;
    i_inst        = inst;
    i_pc          = {$urandom(), $urandom()} & ~64'h3;
    i_pc_old      = i_pc - 64'd4;
    i_pc_pred     = {$urandom(), $urandom()};
    i_csr_rdata   = {$urandom(), $urandom()};
    @(posedge i_clk);
    while (!o_fetched_ack && n < WAIT_MAX) begin
      @(posedge i_clk);
      n++;
    end
    if (n == WAIT_MAX) abort_on_timeout("fetch ack never came");
    @(negedge i_clk);
    i_fetched_req = 1'b0;
  endtask

  task automatic pull_item();
    int n;
    n = 0;
    while (!o_decoded_req && n < WAIT_MAX) begin
      @(negedge i_clk);
      n++;
    end
    if (n == WAIT_MAX) abort_on_timeout("decoded request never came");
    i_decoded_ack = 1'b1;
    @(negedge i_clk);
    i_decoded_ack = 1'b0;
  endtask

  task automatic decode_item(input logic [31:0] inst);
    push_item(inst);
    pull_item();
  endtask

  task automatic decode_random(input logic [6:0] op, input int count);
    repeat (count) decode_item(rand_inst(op));
  endtask

  task automatic write_reg(input reg_idx_t rd, input logic [XLEN-1:0] data);
    {i_wb_en, i_wb_rd, i_wb_data} = {1'b1, rd, data};
    @(negedge i_clk);
    i_wb_en = 1'b0;
    if (rd != 5'd0) shadow[rd] = data; // x0 ignores writes.
  endtask

  task automatic fill_regs();
    for (int r = 0; r < 32; r++) begin
      write_reg(5'(r), {$urandom(), $urandom()});
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - mark);
    mark = errors;
  endtask

  task automatic run_tests();
    decode_item(rand_inst(op_imm));
    end_test("reset and handshake");
    push_item(rand_inst(op_reg));
    fork
      push_item(rand_inst(op_store));
      begin
        repeat (4) @(negedge i_clk);
        i_decoded_ack = 1'b1;
      end
    join
    @(negedge i_clk);
    i_decoded_ack = 1'b0;
    end_test("back-pressure");
    fill_regs();
    decode_random(op_reg, 12);
    decode_random(op_imm, 12);
    decode_random(op_lui, 6);
    decode_random(op_auipc, 6);
    decode_item({12'h005, 5'd0, 3'd0, 5'd1, op_imm}); // addi x1, x0, 5.
    end_test("alu decode");
    fill_regs();
    decode_random(op_load, 16);
    decode_random(op_store, 16);
    end_test("memory decode");
    decode_random(op_branch, 12);
    decode_random(op_jal, 8);
    decode_random(op_jalr, 12);
    end_test("control flow");
    for (int f = 1; f < 8; f++) begin
      if (f != 4) begin
        decode_item(csr_inst(3'(f), 12'($urandom())));
        decode_item(csr_inst(3'(f), csr_mcycle_addr));
      end
    end
    end_test("csr decode");
  endtask

  initial begin
    void'($urandom(32'h67c0));
    i_clk         = 1'b0;
    i_rst         = 1'b1;
    i_fetched_req = 1'b0;
    i_decoded_ack = 1'b0;
    i_inst        = '0;
    i_pc          = '0;
    i_pc_old      = '0;
    i_pc_pred     = '0;
    i_wb_en       = 1'b0;
    i_wb_rd       = '0;
    i_wb_data     = '0;
    i_csr_rdata   = '0;
    foreach (shadow[k]) shadow[k] = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    fork
      run_tests();
      @(stop_ev);
    join_any
    disable fork;
    $display("tests %0d, items %0d, errors %0d", tests, items, errors);
    if (errors == 0 && !timed_out) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* hdl/decode_top.sv */
// rv64i instruction decode stage.
// capture register, decoder, immediate and operand logic and the register file.
module decode_top import rv_decode_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_fetched_req,
  output logic            o_fetched_ack,
  input  logic            i_decoded_ack,
  output logic            o_decoded_req,
  input  logic [31:0]     i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_pc_old,
  input  logic [XLEN-1:0] i_pc_pred,
  input  logic            i_wb_en,
  input  reg_idx_t        i_wb_rd,
  input  logic [XLEN-1:0] i_wb_data,
  input  logic [XLEN-1:0] i_csr_rdata,
  output logic            o_rs1_ren,
  output reg_idx_t        o_rs1,
  output logic            o_rs2_ren,
  output reg_idx_t        o_rs2,
  output reg_idx_t        o_rd,
  output itype_e          o_itype,
  output logic [6:0]      o_opcode,
  output logic [2:0]      o_funct3,
  output logic [6:0]      o_funct7,
  output logic            o_memren,
  output logic            o_memwen,
  output logic [XLEN-1:0] o_memaddr,
  output logic [XLEN-1:0] o_memwdata,
  output logic [XLEN-1:0] o_op1,
  output logic [XLEN-1:0] o_op2,
  output logic [XLEN-1:0] o_t1,
  output logic [11:0]     o_csr_addr,
  output csr_op_e         o_csr_op,
  output logic [XLEN-1:0] o_csr_wdata,
  output logic [XLEN-1:0] o_pc_pred,
  output logic            o_skip_difftest
);

  logic [31:0]     inst_q;
  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic [XLEN-1:0] imm;
  logic            use_zimm;

  decode_ctrl #(.XLEN(XLEN)) u_ctrl (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fetched_req (i_fetched_req),
    .o_fetched_ack (o_fetched_ack),
    .i_decoded_ack (i_decoded_ack),
    .o_decoded_req (o_decoded_req),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .i_pc_old      (i_pc_old),
    .i_pc_pred     (i_pc_pred),
    .o_inst        (inst_q),
    .o_pc          (pc_q),
    .o_pc_old      (),          // previous pc is held for trace only.
    .o_pc_pred     (o_pc_pred)
  );

  inst_decoder u_dec (
    .i_inst          (inst_q),
    .o_itype         (o_itype),
    .o_opcode        (o_opcode),
    .o_funct3        (o_funct3),
    .o_funct7        (o_funct7),
    .o_rs1           (o_rs1),
    .o_rs1_ren       (o_rs1_ren),
    .o_rs2           (o_rs2),
    .o_rs2_ren       (o_rs2_ren),
    .o_rd            (o_rd),
    .o_memren        (o_memren),
    .o_memwen        (o_memwen),
    .o_csr_addr      (o_csr_addr),
    .o_csr_op        (o_csr_op),
    .o_use_zimm      (use_zimm),
    .o_skip_difftest (o_skip_difftest)
  );

  reg_file #(.XLEN(XLEN)) u_rf (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1      (o_rs1),
    .i_rs1_ren  (o_rs1_ren),
    .i_rs2      (o_rs2),
    .i_rs2_ren  (o_rs2_ren),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wb_en    (i_wb_en),
    .i_wb_rd    (i_wb_rd),
    .i_wb_data  (i_wb_data)
  );

  imm_gen #(.XLEN(XLEN)) u_imm (
    .i_inst  (inst_q),
    .i_itype (o_itype),
    .o_imm   (imm)
  );

  operand_sel #(.XLEN(XLEN)) u_opsel (
    .i_itype     (o_itype),
    .i_opcode    (o_opcode),
    .i_use_zimm  (use_zimm),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (imm),
    .i_pc        (pc_q),
    .i_csr_rdata (i_csr_rdata),
    .o_op1       (o_op1),
    .o_op2       (o_op2),
    .o_t1        (o_t1),
    .o_memaddr   (o_memaddr),
    .o_memwdata  (o_memwdata),
    .o_csr_wdata (o_csr_wdata)
  );

endmodule

/* hdl/reg_file.sv */
// integer register file.
// 31 writable registers plus x0, two async read ports and one write port.
module reg_file import rv_decode_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  reg_idx_t        i_rs1,
  input  logic            i_rs1_ren,
  input  reg_idx_t        i_rs2,
  input  logic            i_rs2_ren,
  output logic [XLEN-1:0] o_rs1_data,
  output logic [XLEN-1:0] o_rs2_data,
  input  logic            i_wb_en,
  input  reg_idx_t        i_wb_rd,
  input  logic [XLEN-1:0] i_wb_data
);

  logic [XLEN-1:0] regs [31:1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb_en && (i_wb_rd != '0)) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  // without bypass a same-cycle write shows up on the next read.
  assign o_rs1_data = (i_rs1_ren && (i_rs1 != '0)) ? regs[i_rs1] : '0;
  assign o_rs2_data = (i_rs2_ren && (i_rs2 != '0)) ? regs[i_rs2] : '0;

endmodule

/* hdl/operand_sel.sv */
// operand selector.
// routes register data, immediate and pc into operands, targets and memory fields.
module operand_sel import rv_decode_pkg::*; #(
  parameter int XLEN = 64
) (
  input  itype_e          i_itype,
  input  logic [6:0]      i_opcode,
  input  logic            i_use_zimm,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_imm,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_csr_rdata,
  output logic [XLEN-1:0] o_op1,
  output logic [XLEN-1:0] o_op2,
  output logic [XLEN-1:0] o_t1,
  output logic [XLEN-1:0] o_memaddr,
  output logic [XLEN-1:0] o_memwdata,
  output logic [XLEN-1:0] o_csr_wdata
);

  logic [XLEN-1:0] rs1_imm;
  logic [XLEN-1:0] pc_imm;

  assign rs1_imm = i_rs1_data + i_imm;
  assign pc_imm  = i_pc + i_imm;

  always_comb begin
    o_op1       = '0;
    o_op2       = '0;
    o_t1        = '0;
    o_memaddr   = '0;
    o_memwdata  = '0;
    o_csr_wdata = '0;
    case (i_itype)
      itype_r, itype_b: begin
        o_op1 = i_rs1_data;
        o_op2 = i_rs2_data;
        if (i_itype == itype_b) o_t1 = pc_imm;
      end
      itype_i: begin
        if (i_opcode == op_jalr) begin
          o_op1 = i_pc; // link value is pc + 4.
          o_op2 = XLEN'(4);
          o_t1  = rs1_imm & ~XLEN'(1);
        end else begin
          o_op1 = i_rs1_data;
          o_op2 = i_imm;
          if (i_opcode == op_load) o_memaddr = rs1_imm;
        end
      end
      itype_s: begin
        o_op1      = i_rs1_data;
        o_op2      = i_imm;
        o_memaddr  = rs1_imm;
        o_memwdata = i_rs2_data;
      end
      itype_u: begin
        o_op1 = (i_opcode == op_lui) ? i_imm : i_pc;
        o_op2 = (i_opcode == op_lui) ? '0 : i_imm;
      end
      itype_j: begin
        o_op1 = i_pc;
        o_op2 = XLEN'(4);
        o_t1  = pc_imm;
      end
      itype_csr: begin
        o_op1       = i_csr_rdata;
        o_csr_wdata = i_use_zimm ? i_imm : i_rs1_data; // imm holds zimm here.
      end
      default: ;
    endcase
  end

endmodule

/* hdl/imm_gen.sv */
// immediate generator.
// builds the sign extended immediate of each format, or zimm for csr.
module imm_gen import rv_decode_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic [31:0]     i_inst,
  input  itype_e          i_itype,
  output logic [XLEN-1:0] o_imm
);

  logic signed [31:0] imm32;

  always_comb begin
    case (i_itype)
      itype_i: begin
        imm32 = {{20{i_inst[31]}}, i_inst[31:20]};
      end
      itype_s: begin
        imm32 = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      end
      itype_b: begin
        imm32 = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                 i_inst[11:8], 1'b0};
      end
      itype_u: begin
        imm32 = {i_inst[31:12], 12'b0};
      end
      itype_j: begin
        imm32 = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                 i_inst[30:21], 1'b0};
      end
      itype_csr: begin
        imm32 = {27'b0, i_inst[19:15]}; // zimm, zero extended.
      end
      default: begin
        imm32 = '0;
      end
    endcase
  end

  // widen to xlen with sign extension.
  assign o_imm = XLEN'(imm32);

endmodule

/* hdl/inst_decoder.sv */
// rv64i instruction decoder.
// classifies the opcode and extracts register, memory and csr fields.
module inst_decoder import rv_decode_pkg::*; (
  input  logic [31:0] i_inst,
  output itype_e      o_itype,
  output logic [6:0]  o_opcode,
  output logic [2:0]  o_funct3,
  output logic [6:0]  o_funct7,
  output reg_idx_t    o_rs1,
  output logic        o_rs1_ren,
  output reg_idx_t    o_rs2,
  output logic        o_rs2_ren,
  output reg_idx_t    o_rd,
  output logic        o_memren,
  output logic        o_memwen,
  output logic [11:0] o_csr_addr,
  output csr_op_e     o_csr_op,
  output logic        o_use_zimm,
  output logic        o_skip_difftest
);

  logic     is_csr;
  reg_idx_t rs1_field;
  reg_idx_t rs2_field;
  reg_idx_t rd_field;

  assign o_opcode  = i_inst[6:0];
  assign o_funct3  = i_inst[14:12];
  assign o_funct7  = i_inst[31:25];
  assign rd_field  = i_inst[11:7];
  assign rs1_field = i_inst[19:15];
  assign rs2_field = i_inst[24:20];

  always_comb begin
    case (o_opcode)
      op_reg:    o_itype = itype_r;
      op_imm,
      op_load,
      op_jalr:   o_itype = itype_i;
      op_store:  o_itype = itype_s;
      op_branch: o_itype = itype_b;
      op_lui,
      op_auipc:  o_itype = itype_u;
      op_jal:    o_itype = itype_j;
      // funct3 of zero is ecall/ebreak, which this stage does not handle.
      op_system: o_itype = (o_funct3 != 3'b000) ? itype_csr : itype_none;
      default:   o_itype = itype_none;
    endcase
  end

  assign is_csr     = (o_itype == itype_csr);
  assign o_use_zimm = is_csr && o_funct3[2];

  always_comb begin
    case (o_itype)
      itype_r,
      itype_i,
      itype_s,
      itype_b:   o_rs1_ren = 1'b1;
      itype_csr: o_rs1_ren = !o_funct3[2]; // immediate form carries zimm instead.
      default:   o_rs1_ren = 1'b0;
    endcase
  end

  assign o_rs2_ren = (o_itype == itype_r) || (o_itype == itype_s) || (o_itype == itype_b);

  assign o_rs1 = o_rs1_ren ? rs1_field : '0;
  assign o_rs2 = o_rs2_ren ? rs2_field : '0;

  // stores and branches have no destination.
  assign o_rd = ((o_itype == itype_s) || (o_itype == itype_b)) ? '0 : rd_field;

  assign o_memren = (o_opcode == op_load);
  assign o_memwen = (o_opcode == op_store);

  assign o_csr_addr      = is_csr ? i_inst[31:20] : '0;
  assign o_csr_op        = is_csr ? csr_op_e'(o_funct3[1:0]) : csr_op_none;
  assign o_skip_difftest = is_csr && (i_inst[31:20] == csr_mcycle_addr);

endmodule

/* hdl/decode_ctrl.sv */
// decode stage control.
// runs the fetch and decoded handshakes and holds the instruction and pcs.
module decode_ctrl #(
  parameter int XLEN = 64
) (
  input  logic            i_clk,
  input  logic            i_rst,
  input  logic            i_fetched_req,
  output logic            o_fetched_ack,
  input  logic            i_decoded_ack,
  output logic            o_decoded_req,
  input  logic [31:0]     i_inst,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_pc_old,
  input  logic [XLEN-1:0] i_pc_pred,
  output logic [31:0]     o_inst,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_pc_old,
  output logic [XLEN-1:0] o_pc_pred
);

  logic fetched_hs;

  // single slot, so accept when empty or when the held item leaves this cycle.
  assign o_fetched_ack = !o_decoded_req || i_decoded_ack;
  assign fetched_hs    = i_fetched_req && o_fetched_ack;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_decoded_req <= 1'b0;
      o_inst        <= '0; // zero decodes as itype none.
    end else begin
      if (fetched_hs) begin
        o_decoded_req <= 1'b1;
        o_inst        <= i_inst;
      end else if (i_decoded_ack) begin
        o_decoded_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (fetched_hs) begin
      o_pc      <= i_pc;
      o_pc_old  <= i_pc_old;
      o_pc_pred <= i_pc_pred;
    end
  end

  // held item must not move while execute has not taken it.
  a_hold_stable: assert property (
    @(posedge i_clk) disable iff (i_rst)
    o_decoded_req && !i_decoded_ack |=> $stable(o_inst) && $stable(o_pc)
      && $stable(o_pc_pred)
  ) else $error("decoded item changed under back-pressure");

endmodule

/* hdl/rv_decode_pkg.sv */
// shared decode definitions for the rv64i decode stage.
// opcodes, instruction classes, csr operations and register indices.
package rv_decode_pkg;

  // base opcodes, inst[6:0].
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_system = 7'b1110011;

  // instruction class, drives immediate format and operand routing.
  typedef enum logic [2:0] {
    itype_none = 3'd0,
    itype_r    = 3'd1,
    itype_i    = 3'd2,
    itype_s    = 3'd3,
    itype_b    = 3'd4,
    itype_u    = 3'd5,
    itype_j    = 3'd6,
    itype_csr  = 3'd7
  } itype_e;

  // csr operation, encoded so that funct3[1:0] maps straight across.
  typedef enum logic [1:0] {
    csr_op_none  = 2'd0,
    csr_op_write = 2'd1, // csrrw / csrrwi.
    csr_op_set   = 2'd2, // csrrs / csrrsi.
    csr_op_clear = 2'd3  // csrrc / csrrci.
  } csr_op_e;

  typedef logic [4:0] reg_idx_t;

  // mcycle differs between core and reference model, so reads of it skip difftest.
  localparam logic [11:0] csr_mcycle_addr = 12'hb00;

endpackage
